// File: cpu_backend.f
rtl/cpu_data_pkg.sv
rtl/cpu_ctrl_pkg.sv
rtl/alu.sv
rtl/ex_mem_pipe_reg.sv
rtl/data_mem.sv
rtl/writeback_unit.sv
rtl/cpu_backend.sv
sim/tb_cpu_backend.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cpu_backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_cpu_backend -f cpu_backend.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_cpu_backend)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# The testbench prints its verdict on a line of its own
if echo "$sim_out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

// File: sim/cpu_backend_golden.txt
# rst pc_next op_a op_b alu_op  wdata mem_en mem_wr  rd reg_wr mem2reg hlt pcs  zero ovf
# then two edges later: wb_en wb_rd wb_data halted (all fields hex)
0 0101 1234 0101 0  0000 0 0  1 1 0 0 0  0 0  1 1 1335 0
0 0102 7fff 0001 0  0000 0 0  2 1 0 0 0  0 1  1 2 8000 0
0 0103 8000 0001 1  0000 0 0  3 1 0 0 0  0 1  1 3 7fff 0
0 0104 0005 0005 1  0000 0 0  4 1 0 0 0  1 0  1 4 0000 0
0 0105 f0f0 3c3c 2  0000 0 0  5 1 0 0 0  0 0  1 5 3030 0
0 0106 f000 000f 3  0000 0 0  6 1 0 0 0  0 0  1 6 f00f 0
0 0107 aaaa aaaa 4  0000 0 0  7 1 0 0 0  1 0  1 7 0000 0
0 0108 0001 000c 5  0000 0 0  8 1 0 0 0  0 0  1 8 1000 0
0 0109 8000 0019 6  0000 0 0  9 1 0 0 0  0 0  1 9 0040 0
0 010a 0000 0042 7  beef 1 1  0 0 0 0 0  0 0  0 0 0042 0
0 010b 0040 0002 0  0000 1 0  a 1 1 0 0  0 0  1 a beef 0
0 010c 0003 0004 0  0000 0 0  0 1 0 0 0  0 0  0 0 0007 0
0 010d 0100 0020 3  0000 0 0  b 0 0 0 0  0 0  0 b 0120 0
0 010e 0000 0555 7  0000 0 0  f 1 0 0 1  0 0  1 f 010e 0
0 010f 0010 0020 0  0000 0 0  c 1 0 1 0  0 0  1 c 0030 1
0 0110 0001 0001 0  0000 0 0  d 1 0 0 0  0 0  0 d 0002 1
0 0111 0000 0001 1  0000 0 0  e 1 0 0 0  0 0  0 e ffff 1
0 0112 1234 00ff 4  0000 0 0  1 1 0 0 0  0 0  0 0 0000 0
1 0113 00ff 0f0f 2  0000 0 0  2 1 0 0 0  0 0  0 0 0000 0
0 0001 0100 0200 0  0000 0 0  3 1 0 0 0  0 0  1 3 0300 0
0 0002 0000 0042 7  0000 1 0  4 1 1 0 0  0 0  1 4 beef 0

// File: sim/tb_cpu_backend.sv
`timescale 1ns/1ns

// Testbench for the execute, memory and write-back stages
module tb_cpu_backend import cpu_data_pkg::*, cpu_ctrl_pkg::*; ();

  localparam int CLK_PERIOD = 4;   // ns
  localparam int NUM_FIELDS = 19;  // Columns on each vector line

  // One line of the golden file, stimulus first and expectations after
  typedef struct packed {
    logic      rst;
    word_t     pc_next;
    word_t     operand_a;
    word_t     operand_b;
    alu_op_t   alu_op;
    mem_ctrl_t mem_ctrl;
    wb_ctrl_t  wb_ctrl;
    logic      exp_zero;     // Same cycle as the stimulus
    logic      exp_ovf;
    logic      exp_wb_en;    // Two edges after the stimulus
    reg_addr_t exp_wb_rd;
    word_t     exp_wb_data;
    logic      exp_halted;
  } vec_t;

  logic      clk;
  logic      rst;
  word_t     pc_next;
  word_t     operand_a;
  word_t     operand_b;
  alu_op_t   alu_op;
  mem_ctrl_t mem_ctrl;
  wb_ctrl_t  wb_ctrl;
  logic      wb_en;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      halted;
  logic      ex_zero;
  logic      ex_ovf;

  vec_t vecs[$];        // Every vector of the golden file in order
  int   n_vec;
  int   mismatch_cnt;
  int   other_err_cnt;  // File problems and the like
  logic loaded;         // Releases the watchdog once the length is known

  cpu_backend #(.MEM_ADDR_W(8)) u_cpu_backend (
    .clk(clk), .rst(rst),
    .pc_next(pc_next), .operand_a(operand_a), .operand_b(operand_b),
    .alu_op(alu_op), .mem_ctrl(mem_ctrl), .wb_ctrl(wb_ctrl),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .halted(halted),
    .ex_zero(ex_zero), .ex_ovf(ex_ovf)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_word(input string name, input int idx, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s vector %0d: got 0x%h expected 0x%h", name, idx, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_rd(input string name, input int idx, input reg_addr_t got,
                          input reg_addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s vector %0d: got 0x%h expected 0x%h", name, idx, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input int idx, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s vector %0d: got 0x%h expected 0x%h", name, idx, got, exp);
      mismatch_cnt++;
    end
  endtask

  //////////////////////////////
  // Golden file and stimulus
  //////////////////////////////
  task automatic load_vectors();
    int               fd;
    int               cnt;
    int               line_no;
    logic [8*256-1:0] line_buf;
    logic [15:0]      f [NUM_FIELDS];  // Raw hex fields of one line
    vec_t             v;
    fd = $fopen("sim/cpu_backend_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file sim/cpu_backend_golden.txt");
      other_err_cnt++;
      return;
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line_buf = '0;
      if ($fgets(line_buf, fd) == 0) break;
      line_no++;
      cnt = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
      if (cnt <= 0) continue;  // Comment or blank line
      if (cnt != NUM_FIELDS) begin
        $display("Golden file line %0d is malformed, it has %0d fields instead of %0d",
                 line_no, cnt, NUM_FIELDS);
        other_err_cnt++;
        continue;
      end
      v.rst                 = f[0][0];
      v.pc_next             = f[1];
      v.operand_a           = f[2];
      v.operand_b           = f[3];
      v.alu_op              = alu_op_t'(f[4][2:0]);
      v.mem_ctrl.write_data = f[5];
      v.mem_ctrl.mem_en     = f[6][0];
      v.mem_ctrl.mem_write  = f[7][0];
      v.wb_ctrl.rd          = f[8][3:0];
      v.wb_ctrl.reg_write   = f[9][0];
      v.wb_ctrl.mem_to_reg  = f[10][0];
      v.wb_ctrl.hlt         = f[11][0];
      v.wb_ctrl.pcs         = f[12][0];
      v.exp_zero            = f[13][0];
      v.exp_ovf             = f[14][0];
      v.exp_wb_en           = f[15][0];
      v.exp_wb_rd           = f[16][3:0];
      v.exp_wb_data         = f[17];
      v.exp_halted          = f[18][0];
      vecs.push_back(v);
    end
    $fclose(fd);
    n_vec = vecs.size();
    if (n_vec == 0) begin
      $display("The golden file holds no vectors");
      other_err_cnt++;
    end
  endtask

  task automatic apply_vector(input vec_t v);
    rst       = v.rst;
    pc_next   = v.pc_next;
    operand_a = v.operand_a;
    operand_b = v.operand_b;
    alu_op    = v.alu_op;
    mem_ctrl  = v.mem_ctrl;
    wb_ctrl   = v.wb_ctrl;
  endtask

  // Bubble that flushes the last two vectors out of the pipeline
  task automatic apply_idle();
    rst       = 1'b0;
    pc_next   = '0;
    operand_a = '0;
    operand_b = '0;
    alu_op    = ALU_ADD;
    mem_ctrl  = '0;
    wb_ctrl   = '0;
  endtask

  task automatic check_flags(input int idx);
    check_bit("ex_zero", idx, ex_zero, vecs[idx].exp_zero);
    check_bit("ex_ovf", idx, ex_ovf, vecs[idx].exp_ovf);
  endtask

  task automatic check_writeback(input int idx);
    check_bit("wb_en", idx, wb_en, vecs[idx].exp_wb_en);
    check_rd("wb_rd", idx, wb_rd, vecs[idx].exp_wb_rd);
    check_word("wb_data", idx, wb_data, vecs[idx].exp_wb_data);
    check_bit("halted", idx, halted, vecs[idx].exp_halted);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    apply_idle();
    rst           = 1'b1;  // Held through the first three edges
    mismatch_cnt  = 0;
    other_err_cnt = 0;
    n_vec         = 0;
    loaded        = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    for (int i = 0; i < n_vec + 2; i++) begin
      #1;  // Drive just after the edge
      if (i < n_vec) begin
        apply_vector(vecs[i]);
      end else begin
        apply_idle();
      end
      #2;  // Outputs settled, next edge still 1 ns away
      if (i < n_vec) check_flags(i);
      if (i >= 2) check_writeback(i - 2);  // Issued two edges ago
      @(posedge clk);
    end
    $display("Done with %0d vectors: %0d mismatches, %0d other errors",
             n_vec, mismatch_cnt, other_err_cnt);
    if (mismatch_cnt == 0 && other_err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog sized from the vector count with some slack for reset and drain
  initial begin
    wait (loaded === 1'b1);
    #((n_vec + 10) * CLK_PERIOD);
    $display("Timeout after %0d cycles, the vector loop never finished", n_vec + 10);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: rtl/cpu_backend.sv
`timescale 1ns/1ns

// Execute, memory and write-back stages of the 16-bit pipeline
module cpu_backend import cpu_data_pkg::*, cpu_ctrl_pkg::*; #(
  parameter int MEM_ADDR_W = $bits(mem_addr_t)  // Data RAM address width
) (
  input  logic      clk,
  input  logic      rst,        // Synchronous, active high
  input  word_t     pc_next,    // Decode-registered next PC
  input  word_t     operand_a,  // Decode-registered rs value
  input  word_t     operand_b,  // Decode-registered rt value or immediate
  input  alu_op_t   alu_op,
  input  mem_ctrl_t mem_ctrl,
  input  wb_ctrl_t  wb_ctrl,
  output logic      wb_en,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output logic      halted,
  output logic      ex_zero,    // For branch logic in a later decode stage
  output logic      ex_ovf
);

  //////////////////////////////
  // Stage wires
  //////////////////////////////
  word_t     ex_result;      // ALU output before the register
  word_t     mem_pc_next;    // Memory-stage copies out of the pipeline register
  word_t     mem_result;
  mem_ctrl_t mem_ctrl_q;
  wb_ctrl_t  mem_wb_ctrl;
  word_t     mem_read_data;  // Load data into write-back

  // Execute
  alu u_alu (.a(operand_a), .b(operand_b), .op(alu_op),
             .result(ex_result), .zero(ex_zero), .ovf(ex_ovf));

  // Execute to memory boundary
  ex_mem_pipe_reg u_ex_mem (
    .clk(clk), .rst(rst),
    .pc_next(pc_next), .alu_result(ex_result),
    .mem_ctrl(mem_ctrl), .wb_ctrl(wb_ctrl),
    .pc_next_q(mem_pc_next), .alu_result_q(mem_result),
    .mem_ctrl_q(mem_ctrl_q), .wb_ctrl_q(mem_wb_ctrl)
  );

  // Memory, addressed by the ALU result
  data_mem #(.MEM_ADDR_W(MEM_ADDR_W)) u_data_mem (
    .clk(clk), .addr(mem_result), .ctrl(mem_ctrl_q), .read_data(mem_read_data)
  );

  // Write-back
  writeback_unit u_wb (
    .clk(clk), .rst(rst),
    .alu_result(mem_result), .read_data(mem_read_data),
    .pc_next(mem_pc_next), .wb_ctrl(mem_wb_ctrl),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .halted(halted)
  );

endmodule

// File: rtl/writeback_unit.sv
`timescale 1ns/1ns

// Memory to write-back register, write-back select and sticky halt
module writeback_unit import cpu_data_pkg::*, cpu_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst,         // Synchronous, active high
  input  word_t     alu_result,  // From the execute-to-memory register
  input  word_t     read_data,   // From data memory
  input  word_t     pc_next,     // From the execute-to-memory register
  input  wb_ctrl_t  wb_ctrl,
  output logic      wb_en,       // Register-file write enable
  output reg_addr_t wb_rd,       // Register-file write address
  output word_t     wb_data,     // Register-file write data
  output logic      halted       // Set by HLT, cleared only by reset
);

  // Payload and controls held for the write-back cycle
  typedef struct packed {
    word_t    alu_result;
    word_t    read_data;
    word_t    pc_next;
    wb_ctrl_t ctrl;
  } mem_wb_t;

  mem_wb_t q;
  logic    halted_q;   // An HLT has reached write-back
  logic    blocked_q;  // An HLT reached write-back before the current instruction

  //////////////////////////////
  // Pipeline register and halt
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      q         <= '0;
      halted_q  <= 1'b0;
      blocked_q <= 1'b0;
    end else begin
      q         <= '{alu_result: alu_result, read_data: read_data,
                     pc_next: pc_next, ctrl: wb_ctrl};
      halted_q  <= halted_q | wb_ctrl.hlt;  // Rises with the HLT itself
      blocked_q <= halted_q;                // One edge later, so HLT still writes back
    end
  end

  //////////////////////////////
  // Write-back select
  //////////////////////////////
  always_comb begin
    if (q.ctrl.pcs) begin
      wb_data = q.pc_next;      // PCS saves the return address
    end else if (q.ctrl.mem_to_reg) begin
      wb_data = q.read_data;    // Loads
    end else begin
      wb_data = q.alu_result;
    end
  end

  assign wb_rd  = q.ctrl.rd;
  assign wb_en  = q.ctrl.reg_write & ~blocked_q & (q.ctrl.rd != '0);  // r0 stays zero
  assign halted = halted_q;

  // The two source selects are exclusive in every legal instruction
  a_one_source: assert property (@(posedge clk) disable iff (rst)
    !(q.ctrl.pcs && q.ctrl.mem_to_reg))
    else $error("writeback_unit: pcs and mem_to_reg both set");

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/1ns

// Memory-stage data RAM, word addressed
module data_mem import cpu_data_pkg::*, cpu_ctrl_pkg::*; #(
  parameter int MEM_ADDR_W = $bits(mem_addr_t)  // Depth is 2**MEM_ADDR_W words
) (
  input  logic      clk,
  input  word_t     addr,       // Registered ALU result
  input  mem_ctrl_t ctrl,       // Registered memory controls
  output word_t     read_data   // Load data, zero unless a load is active
);

  localparam int DEPTH = 2 ** MEM_ADDR_W;

  word_t                  mem [DEPTH];  // Storage, contents survive reset
  logic [MEM_ADDR_W-1:0]  idx;          // Low address bits pick the word
  logic                   do_write;
  logic                   do_read;

  assign idx      = addr[MEM_ADDR_W-1:0];
  assign do_write = ctrl.mem_en &  ctrl.mem_write;
  assign do_read  = ctrl.mem_en & ~ctrl.mem_write;

  //////////////////////////////
  // Store port
  //////////////////////////////
  // The write lands on the edge closing the memory cycle
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[idx] <= ctrl.write_data;
    end
  end

  //////////////////////////////
  // Load port
  //////////////////////////////
  // Asynchronous read so the load is ready before the write-back register
  always_comb begin
    if (do_read) begin
      read_data = mem[idx];
    end else begin
      read_data = '0;  // Keeps the write-back mux input clean on non-loads
    end
  end

  // An address past the end would silently alias onto a lower word
  a_addr_in_range: assert property (@(posedge clk)
    ctrl.mem_en |-> ((addr >> MEM_ADDR_W) == '0))
    else $error("data_mem: address 0x%h outside the RAM", addr);

endmodule

// File: rtl/ex_mem_pipe_reg.sv
`timescale 1ns/1ns

// Execute to memory pipeline register
module ex_mem_pipe_reg import cpu_data_pkg::*, cpu_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst,           // Synchronous, active high
  input  word_t     pc_next,       // Next PC carried for PCS
  input  word_t     alu_result,    // ALU output of the execute stage
  input  mem_ctrl_t mem_ctrl,      // Controls used one stage down
  input  wb_ctrl_t  wb_ctrl,       // Controls used two stages down
  output word_t     pc_next_q,
  output word_t     alu_result_q,  // Doubles as the data memory address
  output mem_ctrl_t mem_ctrl_q,
  output wb_ctrl_t  wb_ctrl_q
);

  // Everything crossing the stage boundary travels in one bundle
  typedef struct packed {
    word_t     pc_next;
    word_t     alu_result;
    mem_ctrl_t mem_ctrl;
    wb_ctrl_t  wb_ctrl;
  } ex_mem_t;

  ex_mem_t d;  // Bundle as it leaves execute
  ex_mem_t q;  // Bundle as memory sees it

  assign d = '{pc_next:    pc_next,
               alu_result: alu_result,
               mem_ctrl:   mem_ctrl,
               wb_ctrl:    wb_ctrl};

  //////////////////////////////
  // Pipeline register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;  // A bubble, no access and no write-back
    end else begin
      q <= d;   // No stalls, so load every cycle
    end
  end

  assign pc_next_q    = q.pc_next;
  assign alu_result_q = q.alu_result;
  assign mem_ctrl_q   = q.mem_ctrl;
  assign wb_ctrl_q    = q.wb_ctrl;

  // Decode must never issue a store without enabling the memory
  a_write_needs_en: assert property (@(posedge clk) disable iff (rst)
    mem_ctrl_q.mem_write |-> mem_ctrl_q.mem_en)
    else $error("ex_mem: mem_write set without mem_en");

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ns

// Execute-stage ALU, purely combinational
module alu import cpu_data_pkg::*; (
  input  word_t   a,       // Operand from rs
  input  word_t   b,       // Operand from rt or the immediate
  input  alu_op_t op,      // Operation picked by decode
  output word_t   result,
  output logic    zero,    // Result is all zeros
  output logic    ovf      // Signed overflow, add and sub only
);

  word_t sum;    // a + b, shared by the result mux and the flag logic
  word_t diff;   // a - b

  assign sum  = a + b;
  assign diff = a - b;

  //////////////////////////////
  // Result select
  //////////////////////////////
  always_comb begin
    case (op)
      ALU_ADD:    result = sum;
      ALU_SUB:    result = diff;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_SLL:    result = a << b[3:0];  // Only the low nibble sets the shift amount
      ALU_SRL:    result = a >> b[3:0];  // Zero fill from the top
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  //////////////////////////////
  // Flags
  //////////////////////////////
  assign zero = (result == '0);

  // Add overflows when both signs agree and the sum sign differs from them
  // Sub overflows when the signs differ and the result sign differs from a
  always_comb begin
    case (op)
      ALU_ADD: ovf = (a[15] == b[15]) && (sum[15] != a[15]);
      ALU_SUB: ovf = (a[15] != b[15]) && (diff[15] != a[15]);
      default: ovf = 1'b0;  // Logic ops and shifts never flag
    endcase
  end

endmodule

// File: rtl/cpu_ctrl_pkg.sv
// Control bundles carried down the pipeline beside the data
package cpu_ctrl_pkg;

  import cpu_data_pkg::*;

  //////////////////////////////
  // Memory-stage controls
  //////////////////////////////
  // Bit layout is {write_data[17:2], mem_en[1], mem_write[0]}
  typedef struct packed {
    word_t write_data;  // Store data, read out of rt by the decode stage
    logic  mem_en;      // Access data memory this cycle
    logic  mem_write;   // Store when set, load when clear
  } mem_ctrl_t;

  //////////////////////////////
  // Write-back-stage controls
  //////////////////////////////
  // Bit layout is {rd[7:4], reg_write[3], mem_to_reg[2], hlt[1], pcs[0]}
  typedef struct packed {
    reg_addr_t rd;          // Destination register
    logic      reg_write;   // Instruction writes the register file
    logic      mem_to_reg;  // Write back load data instead of the ALU result
    logic      hlt;         // Halt instruction
    logic      pcs;         // Write back the next PC
  } wb_ctrl_t;

endpackage

// File: rtl/cpu_data_pkg.sv
// Datapath types shared by every back-end stage
package cpu_data_pkg;

  //////////////////////////////
  // Widths that carry a meaning
  //////////////////////////////
  typedef logic [15:0] word_t;      // Data word, PC value or ALU result
  typedef logic [3:0]  reg_addr_t;  // Register-file index, r0 is hard-wired to zero

  // Word address into data memory at the default depth of 256 words
  // The top level sizes the real RAM through its own MEM_ADDR_W parameter
  typedef logic [7:0]  mem_addr_t;

  //////////////////////////////
  // ALU opcodes
  //////////////////////////////
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,  // a + b with signed overflow
    ALU_SUB    = 3'd1,  // a - b with signed overflow
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLL    = 3'd5,  // Logical left shift by b[3:0]
    ALU_SRL    = 3'd6,  // Logical right shift by b[3:0]
    ALU_PASS_B = 3'd7   // Used for immediates and address pass-through
  } alu_op_t;

endpackage
